//--- src/mem_pkg.sv
package mem_pkg;

  ////////////////////
  // Operations and causes
  ////////////////////

  typedef enum logic [3:0] {
    lsu_none = 4'd0,
    lsu_lb   = 4'd1,
    lsu_lbu  = 4'd2,
    lsu_lh   = 4'd3,
    lsu_lhu  = 4'd4,
    lsu_lw   = 4'd5,
    lsu_sb   = 4'd6,
    lsu_sh   = 4'd7,
    lsu_sw   = 4'd8
  } lsu_op_t;

  localparam logic [3:0] cause_load_misaligned  = 4'd4;
  localparam logic [3:0] cause_store_misaligned = 4'd6;

  ////////////////////
  // Records
  ////////////////////

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    lsu_op_t     lsu_op;
    logic [31:0] address;
    logic [31:0] sdata;
    logic        wren;
    logic [4:0]  waddr;
    logic [31:0] wdata;  // ALU result
  } mem_in_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // Zero for loads
  } ram_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } ram_rsp_t;

  typedef struct packed {
    logic        wren;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } reg_write_t;

  typedef struct packed {
    logic        valid;
    logic        exception;
    logic [31:0] epc;
    logic [3:0]  ecause;
    logic [31:0] etval;
  } exc_report_t;

  function automatic logic is_load(lsu_op_t op);
    return op inside {lsu_lb, lsu_lbu, lsu_lh, lsu_lhu, lsu_lw};
  endfunction

  function automatic logic is_store(lsu_op_t op);
    return op inside {lsu_sb, lsu_sh, lsu_sw};
  endfunction

endpackage

//--- src/store_align.sv
`timescale 1ns/1ps

module store_align import mem_pkg::*; (
  input  logic [1:0]  address,
  input  lsu_op_t     lsu_op,
  input  logic [31:0] sdata,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  output logic        misaligned
);

  always_comb begin
    wdata = sdata;
    wstrb = 4'b0000;
    misaligned = 1'b0;
    case (lsu_op)
      lsu_sb: begin
        wdata = {4{sdata[7:0]}};  // Same byte on every lane
        wstrb = 4'b0001 << address;
      end
      lsu_sh: begin
        wdata = {2{sdata[15:0]}};
        wstrb = address[1] ? 4'b1100 : 4'b0011;
        misaligned = address[0];
      end
      lsu_sw: begin
        wstrb = 4'b1111;
        misaligned = |address;
      end
      default: begin
        wstrb = 4'b0000;  // Not a store
      end
    endcase
    if (misaligned) begin
      wstrb = 4'b0000;
    end
  end

endmodule

//--- src/load_align.sv
`timescale 1ns/1ps

module load_align import mem_pkg::*; (
  input  logic [1:0]  address,
  input  lsu_op_t     lsu_op,
  input  logic [31:0] rdata,
  output logic [31:0] result,
  output logic        misaligned
);

  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  always_comb begin
    case (address)
      2'd0: lane_b = rdata[7:0];
      2'd1: lane_b = rdata[15:8];
      2'd2: lane_b = rdata[23:16];
      default: lane_b = rdata[31:24];
    endcase
    lane_h = address[1] ? rdata[31:16] : rdata[15:0];
  end

  always_comb begin
    result = rdata;
    misaligned = 1'b0;
    case (lsu_op)
      lsu_lb: result = {{24{lane_b[7]}}, lane_b};
      lsu_lbu: result = {24'd0, lane_b};
      lsu_lh: begin
        result = {{16{lane_h[15]}}, lane_h};
        misaligned = address[0];
      end
      lsu_lhu: begin
        result = {16'd0, lane_h};
        misaligned = address[0];
      end
      lsu_lw: begin
        misaligned = |address;  // Word must sit on lane 0
      end
      default: begin
        result = rdata;
      end
    endcase
  end

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_pkg::*; #(
  parameter int wait_cycles = 2,
  parameter int ram_words = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  ram_req_t req,
  output ram_rsp_t rsp
);

  localparam int cnt_w = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
  localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

  logic [31:0]      mem [ram_words];
  logic [cnt_w-1:0] cnt;
  logic [idx_w-1:0] word_idx;
  logic             ready;

  ////////////////////
  // Wait counter
  ////////////////////

  assign ready = req.valid && (cnt == cnt_w'(wait_cycles));

  always_ff @(posedge clk) begin
    if (!rst) begin
      cnt <= '0;
    end else if (req.valid && !ready) begin
      cnt <= cnt + 1'b1;
    end else begin
      cnt <= '0;  // Restart after ready or when idle
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  assign word_idx = idx_w'(req.addr[31:2] % ram_words);

  always_ff @(posedge clk) begin
    if (ready) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    rsp.ready = ready;
    rsp.rdata = mem[word_idx];  // Read is not destructive
  end

endmodule

//--- src/memory_ctrl.sv
`timescale 1ns/1ps

module memory_ctrl import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  mem_in_t     ex_in,
  input  logic        clear,
  input  logic [31:0] st_wdata,
  input  logic [3:0]  st_wstrb,
  input  logic        st_misaligned,
  input  logic [31:0] ld_result,
  input  logic        ld_misaligned,
  output ram_req_t    req,
  input  ram_rsp_t    rsp,
  output reg_write_t  wb,
  output reg_write_t  fwd,
  output exc_report_t exc,
  output logic        stall
);

  logic       ld_op;
  logic       st_op;
  logic       misaligned;
  logic       issue;
  logic       done;
  reg_write_t fwd_q;

  ////////////////////
  // Decision
  ////////////////////

  always_comb begin
    ld_op = is_load(ex_in.lsu_op);
    st_op = is_store(ex_in.lsu_op);
    misaligned = ex_in.valid && ((ld_op && ld_misaligned) || (st_op && st_misaligned));
    issue = ex_in.valid && (ld_op || st_op) && !misaligned && !clear;
    stall = issue && !rsp.ready;  // Low under clear since issue is
    done = ex_in.valid && !stall && !clear;
  end

  ////////////////////
  // Memory request
  ////////////////////

  always_comb begin
    req.valid = issue;
    req.addr = ex_in.address;
    req.wdata = st_wdata;
    req.wstrb = st_op ? st_wstrb : 4'b0000;
  end

  ////////////////////
  // Writeback and exception
  ////////////////////

  always_comb begin
    wb.wren = done && ex_in.wren && !misaligned && (ex_in.waddr != 5'd0);
    wb.waddr = ex_in.waddr;
    wb.wdata = ld_op ? ld_result : ex_in.wdata;
  end

  always_comb begin
    exc.valid = done;
    exc.exception = done && misaligned;
    exc.epc = ex_in.pc;
    exc.ecause = 4'd0;
    exc.etval = 32'd0;
    if (misaligned) begin
      exc.ecause = ld_op ? cause_load_misaligned : cause_store_misaligned;
      exc.etval = ex_in.address;  // Faulting address
    end
  end

  ////////////////////
  // Forwarding stage
  ////////////////////

  always_ff @(posedge clk) begin
    fwd_q.waddr <= wb.waddr;
    fwd_q.wdata <= wb.wdata;
    if (!rst) begin
      fwd_q.wren <= 1'b0;
    end else begin
      fwd_q.wren <= wb.wren;
    end
  end

  assign fwd = fwd_q;

endmodule

//--- src/memory_top.sv
`timescale 1ns/1ps

module memory_top import mem_pkg::*; #(
  parameter int wait_cycles = 2,
  parameter int ram_words = 256
) (
  input  logic        clk,
  input  logic        rst,
  input  mem_in_t     ex_in,
  input  logic        clear,
  output reg_write_t  wb,
  output reg_write_t  fwd,
  output exc_report_t exc,
  output logic        stall
);

  logic [31:0] st_wdata;
  logic [3:0]  st_wstrb;
  logic        st_misaligned;
  logic [31:0] ld_result;
  logic        ld_misaligned;
  ram_req_t    req;
  ram_rsp_t    rsp;

  memory_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ex_in         (ex_in),
    .clear         (clear),
    .st_wdata      (st_wdata),
    .st_wstrb      (st_wstrb),
    .st_misaligned (st_misaligned),
    .ld_result     (ld_result),
    .ld_misaligned (ld_misaligned),
    .req           (req),
    .rsp           (rsp),
    .wb            (wb),
    .fwd           (fwd),
    .exc           (exc),
    .stall         (stall)
  );

  store_align u_store (
    .address    (ex_in.address[1:0]),
    .lsu_op     (ex_in.lsu_op),
    .sdata      (ex_in.sdata),
    .wdata      (st_wdata),
    .wstrb      (st_wstrb),
    .misaligned (st_misaligned)
  );

  load_align u_load (
    .address    (ex_in.address[1:0]),
    .lsu_op     (ex_in.lsu_op),
    .rdata      (rsp.rdata),
    .result     (ld_result),
    .misaligned (ld_misaligned)
  );

  data_ram #(
    .wait_cycles (wait_cycles),
    .ram_words   (ram_words)
  ) u_ram (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

endmodule

//--- dv/memory_asserts.sv
`timescale 1ns/1ps

module memory_asserts import mem_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       clear,
  input logic       stall,
  input reg_write_t wb,
  input reg_write_t fwd
);

  ////////////////////
  // Stage rules
  ////////////////////

  a_no_stall_on_clear: assert property (@(posedge clk) disable iff (!rst) clear |-> !stall)
    else $error("stall is high while clear is high");

  a_no_write_on_stall: assert property (@(posedge clk) disable iff (!rst) stall |-> !wb.wren)
    else $error("register write while the stage stalls");

  a_fwd_follows_wb: assert property (@(posedge clk) disable iff (!rst)
    $past(rst) |-> fwd.wren == $past(wb.wren) && (!fwd.wren || fwd == $past(wb)))
    else $error("fwd differs from the wb of the cycle before");

endmodule

//--- dv/memory_tb.sv
`timescale 1ns/1ps

module memory_tb import mem_pkg::*; ();

  localparam int wait_cycles = 2;
  localparam int ram_words = 256;
  localparam int num_random = 600;
  localparam int never = 1000;  // Clear cycle that never comes
  // Covers the fill, up to 100 directed records and the random mix
  localparam int cycle_limit = (ram_words + 100 + num_random) * (wait_cycles + 2);

  typedef struct packed {
    reg_write_t  wb;
    exc_report_t exc;
    logic [31:0] word;  // Memory word after the access
  } expect_t;

  logic        clk;
  logic        rst;
  mem_in_t     ex_in;
  logic        clear;
  reg_write_t  wb;
  reg_write_t  fwd;
  exc_report_t exc;
  logic        stall;
  logic [31:0] ref_mem [ram_words];
  logic [31:0] rng_state = 32'd67275;
  logic [31:0] pc_next = 32'h1000;
  logic        checking = 1'b0;
  string       test_name = "reset";
  expect_t     exp_r;
  int          ref_idx;
  int          cycles = 0;

  memory_top #(.wait_cycles(wait_cycles), .ram_words(ram_words)) u_dut (.*);
  bind memory_top memory_asserts u_asserts (.clk, .rst, .clear, .stall, .wb, .fwd);

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic load_op(lsu_op_t op);
    return op == lsu_lb || op == lsu_lbu || op == lsu_lh || op == lsu_lhu || op == lsu_lw;
  endfunction

  function automatic logic store_op(lsu_op_t op);
    return op == lsu_sb || op == lsu_sh || op == lsu_sw;
  endfunction

  function automatic logic bad_align(lsu_op_t op, logic [1:0] off);
    if (op == lsu_lh || op == lsu_lhu || op == lsu_sh) return off[0];
    if (op == lsu_lw || op == lsu_sw) return off != 2'd0;
    return 1'b0;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic expect_t ref_model(mem_in_t rec, logic clr, logic [31:0] word);
    expect_t     e;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] data;
    e = '0;
    e.word = word;
    if (!rec.valid || clr) return e;
    e.exc.valid = 1'b1;
    e.exc.epc = rec.pc;
    if (bad_align(rec.lsu_op, rec.address[1:0])) begin
      e.exc.exception = 1'b1;
      e.exc.ecause = load_op(rec.lsu_op) ? 4'd4 : 4'd6;  // Load or store misaligned
      e.exc.etval = rec.address;
      return e;
    end
    b = 8'(word >> (8 * rec.address[1:0]));
    h = 16'(word >> (16 * rec.address[1]));
    case (rec.lsu_op)
      lsu_lb: data = {{24{b[7]}}, b};
      lsu_lbu: data = {24'd0, b};
      lsu_lh: data = {{16{h[15]}}, h};
      lsu_lhu: data = {16'd0, h};
      lsu_lw: data = word;
      default: data = rec.wdata;
    endcase
    case (rec.lsu_op)
      lsu_sb: e.word[8 * rec.address[1:0] +: 8] = rec.sdata[7:0];
      lsu_sh: e.word[16 * rec.address[1] +: 16] = rec.sdata[15:0];
      lsu_sw: e.word = rec.sdata;
      default: e.word = word;
    endcase
    e.wb.wren = rec.wren && rec.waddr != 5'd0;
    e.wb.waddr = rec.waddr;
    e.wb.wdata = data;
    return e;
  endfunction

  // Fields that carry no meaning are zeroed before a compare
  function automatic reg_write_t seen_wb(reg_write_t w);
    reg_write_t r;
    r = '0;
    if (w.wren) r = w;
    return r;
  endfunction

  function automatic exc_report_t seen_exc(exc_report_t x);
    exc_report_t r;
    r = '0;
    if (x.valid) begin
      r = x;
      if (!x.exception) begin
        r.ecause = 4'd0;
        r.etval = 32'd0;
      end
    end
    return r;
  endfunction

  task automatic check(string what, logic [127:0] expected, logic [127:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Done: errors found");
      $fatal(1, "mismatch in %s", what);
    end
  endtask

  function automatic mem_in_t make_rec(lsu_op_t op, logic [31:0] addr, logic [31:0] sdata,
                                       logic [4:0] waddr, logic [31:0] wdata);
    mem_in_t r;
    r = '0;
    r.valid = 1'b1;
    r.lsu_op = op;
    r.address = addr;
    r.sdata = sdata;
    r.wren = !store_op(op);
    r.waddr = waddr;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic mem_in_t random_rec();
    mem_in_t r;
    r = '0;
    r.lsu_op = lsu_op_t'(4'(next_rand() % 9));
    r.address = next_rand();
    r.sdata = next_rand();
    r.waddr = 5'(next_rand());
    r.wdata = next_rand();
    r.wren = !store_op(r.lsu_op);
    r.valid = (next_rand() % 8) != 0;
    if ((next_rand() % 4) != 0 && bad_align(r.lsu_op, r.address[1:0])) begin
      r.address[1:0] = 2'b00;  // Mostly aligned
    end
    return r;
  endfunction

  // Holds one record until stall is low and pulses clear in cycle clear_at
  task automatic send(mem_in_t rec, int clear_at);
    int k;
    int exp_stalls;
    k = 0;
    exp_stalls = 0;
    rec.pc = pc_next;
    pc_next += 32'd4;
    if (rec.valid && (load_op(rec.lsu_op) || store_op(rec.lsu_op)) &&
        !bad_align(rec.lsu_op, rec.address[1:0])) begin
      exp_stalls = (clear_at < wait_cycles) ? clear_at : wait_cycles;
    end
    ex_in = rec;
    clear = (clear_at == 0);
    @(negedge clk);
    while (stall) begin
      k++;
      @(posedge clk);
      #5 clear = (k == clear_at);
      @(negedge clk);
    end
    check("stall cycles", 128'(exp_stalls), 128'(k));
    @(posedge clk);
    #5 clear = 1'b0;
  endtask

  ////////////////////
  // Clock, limit and compare
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the records did not finish within %0d cycles", cycle_limit);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  always @(negedge clk) begin
    if (checking && !stall) begin  // Record completes in this cycle
      ref_idx = int'(ex_in.address[31:2] % ram_words);
      exp_r = ref_model(ex_in, clear, ref_mem[ref_idx]);
      check("wb", 128'(seen_wb(exp_r.wb)), 128'(seen_wb(wb)));
      check("exc", 128'(seen_exc(exp_r.exc)), 128'(seen_exc(exc)));
      ref_mem[ref_idx] = exp_r.word;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [31:0] a;
    int          clear_at;
    rst = 1'b0;
    ex_in = '0;
    clear = 1'b0;
    repeat (16) @(posedge clk);
    #5 rst = 1'b1;
    checking = 1'b1;
    test_name = "fill";
    for (int i = 0; i < ram_words; i++) begin
      a = 32'(4 * i);
      send(make_rec(lsu_sw, a, (a * 32'h9e37_79b1) ^ 32'h0f1e_2d3c, 5'd0, 32'd0), never);
    end
    test_name = "store_load";
    for (int off = 0; off < 4; off++) begin
      send(make_rec(lsu_sb, 32'h200 + 32'(off), next_rand(), 5'd0, 32'd0), never);
    end
    send(make_rec(lsu_sh, 32'h204, next_rand(), 5'd0, 32'd0), never);
    send(make_rec(lsu_sh, 32'h206, next_rand(), 5'd0, 32'd0), never);
    send(make_rec(lsu_sw, 32'h208, next_rand(), 5'd0, 32'd0), never);
    for (int w = 0; w < 4; w++) begin
      for (int off = 0; off < 4; off++) begin
        a = 32'h200 + 32'(4 * w + off);
        send(make_rec(lsu_lb, a, 32'd0, 5'(off + 1), 32'd0), never);
        send(make_rec(lsu_lbu, a, 32'd0, 5'(off + 5), 32'd0), never);
        if (off % 2 == 0) begin
          send(make_rec(lsu_lh, a, 32'd0, 5'(off + 9), 32'd0), never);
          send(make_rec(lsu_lhu, a, 32'd0, 5'(off + 13), 32'd0), never);
        end
        if (off == 0) begin
          send(make_rec(lsu_lw, a, 32'd0, 5'd20, 32'd0), never);
        end
      end
    end
    test_name = "timing";
    repeat (3) send(make_rec(lsu_lw, 32'h208, 32'd0, 5'd9, 32'd0), never);
    test_name = "misaligned";
    send(make_rec(lsu_lh, 32'h301, 32'd0, 5'd3, 32'd0), never);
    send(make_rec(lsu_lhu, 32'h303, 32'd0, 5'd4, 32'd0), never);
    send(make_rec(lsu_lw, 32'h302, 32'd0, 5'd5, 32'd0), never);
    send(make_rec(lsu_sh, 32'h305, next_rand(), 5'd0, 32'd0), never);
    send(make_rec(lsu_sw, 32'h30a, next_rand(), 5'd0, 32'd0), never);
    send(make_rec(lsu_sw, 32'h307, next_rand(), 5'd0, 32'd0), never);
    for (int w = 0; w < 3; w++) begin
      send(make_rec(lsu_lw, 32'h300 + 32'(4 * w), 32'd0, 5'd6, 32'd0), never);
    end
    test_name = "alu";
    send(make_rec(lsu_none, 32'd0, 32'd0, 5'd7, 32'h1234_5678), never);
    send(make_rec(lsu_none, 32'd0, 32'd0, 5'd0, 32'hffff_ffff), never);
    test_name = "clear";
    send(make_rec(lsu_sw, 32'h400, next_rand(), 5'd0, 32'd0), never);
    send(make_rec(lsu_sw, 32'h400, next_rand(), 5'd0, 32'd0), 1);
    send(make_rec(lsu_sb, 32'h401, next_rand(), 5'd0, 32'd0), 0);
    send(make_rec(lsu_sh, 32'h402, next_rand(), 5'd0, 32'd0), wait_cycles);
    send(make_rec(lsu_lw, 32'h400, 32'd0, 5'd8, 32'd0), 1);
    send(make_rec(lsu_lw, 32'h400, 32'd0, 5'd8, 32'd0), never);
    test_name = "random";
    for (int n = 0; n < num_random; n++) begin
      clear_at = never;
      if ((next_rand() % 5) == 0) clear_at = int'(next_rand() % (wait_cycles + 2));
      send(random_rec(), clear_at);
    end
    ex_in = '0;
    @(negedge clk);
    @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- memory_top.f
src/mem_pkg.sv
src/store_align.sv
src/load_align.sv
src/data_ram.sv
src/memory_ctrl.sv
src/memory_top.sv
dv/memory_asserts.sv
dv/memory_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memory_tb
FILELIST  ?= memory_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim lint clean

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
